// File: sf2_config_bridge.f
cfg_bridge_pkg.sv
cfg_apb_if.sv
apb_bridge_seq.sv
apb_slave_decoder.sv
cfg_regs.sv
sf2_config_bridge.sv
tb_apb_slave_model.sv
sf2_config_bridge_tb.sv

// File: sf2_config_bridge_tb.sv
module sf2_config_bridge_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {act_write, act_read, act_init} action_t;

    // One table row with a byte address for readability
    typedef struct packed {
        action_t               act;
        logic [15:0]           addr;
        cfg_bridge_pkg::data_t wdata;
        cfg_bridge_pkg::data_t exp_rdata;
        logic                  exp_err;
        logic                  exp_cfg;
        logic                  exp_clr;
    } row_t;

    logic                   FIC_2_APB_M_PCLK;
    logic                   FIC_2_APB_M_PRESET_N;
    logic                   m_psel;
    logic                   m_penable;
    logic                   m_pwrite;
    cfg_bridge_pkg::paddr_t m_paddr;
    cfg_bridge_pkg::data_t  m_pwdata;
    cfg_bridge_pkg::data_t  m_prdata;
    logic                   m_pready;
    logic                   m_pslverr;
    logic                   init_done;
    logic                   config_done;
    logic                   clr_init_done;

    // Slave port groups indexed 0 MDDR, 1 FDDR, 2 SERDESIF_0 and 3 SERDESIF_1
    logic                   s_psel    [4];
    logic                   s_penable [4];
    logic                   s_pwrite  [4];
    cfg_bridge_pkg::paddr_t s_paddr   [4];
    cfg_bridge_pkg::data_t  s_pwdata  [4];
    cfg_bridge_pkg::data_t  s_prdata  [4];
    logic                   s_pready  [4];
    logic                   s_pslverr [4];

    row_t rows[$];
    int   error_count;
    int   pass_count;
    bit   table_ready;

    //--------------------------------------------------------------------------
    // DUT and slave models
    //--------------------------------------------------------------------------
    sf2_config_bridge #(
        .sync_stages (2)
    ) i_dut (
        .FIC_2_APB_M_PCLK     (FIC_2_APB_M_PCLK),
        .FIC_2_APB_M_PRESET_N (FIC_2_APB_M_PRESET_N),
        .m_psel        (m_psel),
        .m_penable     (m_penable),
        .m_pwrite      (m_pwrite),
        .m_paddr       (m_paddr),
        .m_pwdata      (m_pwdata),
        .m_prdata      (m_prdata),
        .m_pready      (m_pready),
        .m_pslverr     (m_pslverr),
        .mddr_psel     (s_psel[0]),
        .mddr_penable  (s_penable[0]),
        .mddr_pwrite   (s_pwrite[0]),
        .mddr_paddr    (s_paddr[0]),
        .mddr_pwdata   (s_pwdata[0]),
        .mddr_prdata   (s_prdata[0]),
        .mddr_pready   (s_pready[0]),
        .mddr_pslverr  (s_pslverr[0]),
        .fddr_psel     (s_psel[1]),
        .fddr_penable  (s_penable[1]),
        .fddr_pwrite   (s_pwrite[1]),
        .fddr_paddr    (s_paddr[1]),
        .fddr_pwdata   (s_pwdata[1]),
        .fddr_prdata   (s_prdata[1]),
        .fddr_pready   (s_pready[1]),
        .fddr_pslverr  (s_pslverr[1]),
        .sdif0_psel    (s_psel[2]),
        .sdif0_penable (s_penable[2]),
        .sdif0_pwrite  (s_pwrite[2]),
        .sdif0_paddr   (s_paddr[2]),
        .sdif0_pwdata  (s_pwdata[2]),
        .sdif0_prdata  (s_prdata[2]),
        .sdif0_pready  (s_pready[2]),
        .sdif0_pslverr (s_pslverr[2]),
        .sdif1_psel    (s_psel[3]),
        .sdif1_penable (s_penable[3]),
        .sdif1_pwrite  (s_pwrite[3]),
        .sdif1_paddr   (s_paddr[3]),
        .sdif1_pwdata  (s_pwdata[3]),
        .sdif1_prdata  (s_prdata[3]),
        .sdif1_pready  (s_pready[3]),
        .sdif1_pslverr (s_pslverr[3]),
        .init_done     (init_done),
        .config_done   (config_done),
        .clr_init_done (clr_init_done)
    );

    // Wait states 0 to 3 across MDDR, FDDR, SERDESIF_0 and SERDESIF_1
    genvar g;
    generate
        for (g = 0; g < 4; g++)
        begin : g_slave
            tb_apb_slave_model #(
                .wait_states (g)
            ) i_model (
                .clk     (FIC_2_APB_M_PCLK),
                .rst_n   (FIC_2_APB_M_PRESET_N),
                .psel    (s_psel[g]),
                .penable (s_penable[g]),
                .pwrite  (s_pwrite[g]),
                .paddr   (s_paddr[g]),
                .pwdata  (s_pwdata[g]),
                .prdata  (s_prdata[g]),
                .pready  (s_pready[g]),
                .pslverr (s_pslverr[g])
            );
        end
    endgenerate

    // 10 ns clock
    initial
    begin
        FIC_2_APB_M_PCLK = 1'b0;
        forever #5 FIC_2_APB_M_PCLK = ~FIC_2_APB_M_PCLK;
    end

    //--------------------------------------------------------------------------
    // Helpers
    //--------------------------------------------------------------------------
    task automatic check_value(input string what, input cfg_bridge_pkg::data_t actual,
                               input cfg_bridge_pkg::data_t expected);
        if (actual !== expected)
        begin
            error_count++;
            $display("Error: %0d ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    // Wait states of the model that the address map selects
    function automatic int waits_for(input logic [15:0] addr);
        if (addr[15])
            return addr[14] ? 3 : 2;
        if (addr[13])
            return 0;
        if (addr[12])
            return 1;
        return 0;
    endfunction

    task automatic add_row(input action_t act, input logic [15:0] addr,
                           input cfg_bridge_pkg::data_t wdata,
                           input cfg_bridge_pkg::data_t exp_rdata,
                           input logic exp_err, input logic exp_cfg, input logic exp_clr);
        row_t r;
        r.act       = act;
        r.addr      = addr;
        r.wdata     = wdata;
        r.exp_rdata = exp_rdata;
        r.exp_err   = exp_err;
        r.exp_cfg   = exp_cfg;
        r.exp_clr   = exp_clr;
        rows.push_back(r);
    endtask

    // One master transfer entered and left 1 ns after a rising edge
    task automatic run_transfer(input logic write, input cfg_bridge_pkg::paddr_t addr,
                                input cfg_bridge_pkg::data_t wdata,
                                output cfg_bridge_pkg::data_t rdata,
                                output logic err, output int cycles);
        m_psel    = 1'b1;
        m_penable = 1'b0;
        m_pwrite  = write;
        m_paddr   = addr;
        m_pwdata  = wdata;
        @(posedge FIC_2_APB_M_PCLK);
        #1;
        m_penable = 1'b1;
        cycles    = 1;
        @(posedge FIC_2_APB_M_PCLK);
        #1;
        // Stalled until the bridge has the slave response
        while (!m_pready)
        begin
            cycles++;
            @(posedge FIC_2_APB_M_PCLK);
            #1;
        end
        rdata = m_prdata;
        err   = m_pslverr;
        // Completing edge
        @(posedge FIC_2_APB_M_PCLK);
        #1;
        cycles++;
        m_psel    = 1'b0;
        m_penable = 1'b0;
    endtask

    task automatic apply_row(input int n, input row_t r);
        cfg_bridge_pkg::data_t rdata;
        logic                  err;
        int                    cycles;
        int                    errs_before;
        action_t               act;
        errs_before = error_count;
        act         = r.act;
        if (act == act_init)
        begin
            init_done = r.wdata[0];
            repeat (5) @(posedge FIC_2_APB_M_PCLK);
            #1;
        end
        else
        begin
            run_transfer(act == act_write, r.addr[15:2], r.wdata, rdata, err, cycles);
            check_value("m_pslverr", err, r.exp_err);
            if (act == act_read)
                check_value("m_prdata", rdata, r.exp_rdata);
            // Master access lasts 3 plus the slave wait states
            check_value("access cycles", cycles, 3 + waits_for(r.addr));
        end
        check_value("config_done", config_done, r.exp_cfg);
        check_value("clr_init_done", clr_init_done, r.exp_clr);
        if (error_count == errs_before)
        begin
            pass_count++;
            $display("Row %0d %s 0x%04h passed", n, act.name(), r.addr);
        end
        else
            $display("Row %0d %s 0x%04h failed", n, act.name(), r.addr);
    endtask

    //--------------------------------------------------------------------------
    // Transfer table
    //--------------------------------------------------------------------------
    task automatic build_table();
        cfg_bridge_pkg::data_t d_mddr;
        cfg_bridge_pkg::data_t d_fddr;
        cfg_bridge_pkg::data_t d_sdif0;
        cfg_bridge_pkg::data_t d_sdif1;
        cfg_bridge_pkg::data_t d_err;
        d_mddr  = $urandom;
        d_fddr  = $urandom;
        d_sdif0 = $urandom;
        d_sdif1 = $urandom;
        d_err   = $urandom;
        // Control register clear after reset
        add_row(act_read,  16'h2000, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);
        // Same word offset in each slave
        add_row(act_write, 16'h0010, d_mddr,  32'h0, 1'b0, 1'b0, 1'b0);
        add_row(act_write, 16'h1010, d_fddr,  32'h0, 1'b0, 1'b0, 1'b0);
        add_row(act_write, 16'h8010, d_sdif0, 32'h0, 1'b0, 1'b0, 1'b0);
        add_row(act_write, 16'hC010, d_sdif1, 32'h0, 1'b0, 1'b0, 1'b0);
        add_row(act_read,  16'h0010, 32'h0, d_mddr,  1'b0, 1'b0, 1'b0);
        add_row(act_read,  16'h1010, 32'h0, d_fddr,  1'b0, 1'b0, 1'b0);
        add_row(act_read,  16'h8010, 32'h0, d_sdif0, 1'b0, 1'b0, 1'b0);
        add_row(act_read,  16'hC010, 32'h0, d_sdif1, 1'b0, 1'b0, 1'b0);
        // Bit 14 below the SERDES region aliases MDDR
        add_row(act_read,  16'h4010, 32'h0, d_mddr,  1'b0, 1'b0, 1'b0);
        add_row(act_read,  16'h200C, 32'h0, 32'h0,   1'b0, 1'b0, 1'b0);
        // Error region at the same word index as the stored MDDR data
        add_row(act_write, 16'h0F10, d_err, 32'h0,   1'b1, 1'b0, 1'b0);
        add_row(act_read,  16'hCF10, 32'h0, 32'h0,   1'b1, 1'b0, 1'b0);
        add_row(act_read,  16'h0010, 32'h0, d_mddr,  1'b0, 1'b0, 1'b0);
        // CONFIG_DONE where only bit 0 counts
        add_row(act_write, 16'h2000, 32'h1, 32'h0,   1'b0, 1'b1, 1'b0);
        add_row(act_read,  16'h2000, 32'h0, 32'h1,   1'b0, 1'b1, 1'b0);
        add_row(act_write, 16'h2000, 32'hFFFF_FFFE, 32'h0, 1'b0, 1'b0, 1'b0);
        add_row(act_read,  16'h2000, 32'h0, 32'h0,   1'b0, 1'b0, 1'b0);
        // INIT_DONE status and the clear request
        add_row(act_init,  16'h0000, 32'h1, 32'h0,   1'b0, 1'b0, 1'b0);
        add_row(act_read,  16'h2004, 32'h0, 32'h1,   1'b0, 1'b0, 1'b0);
        add_row(act_write, 16'h2008, 32'h1, 32'h0,   1'b0, 1'b0, 1'b1);
        add_row(act_read,  16'h2008, 32'h0, 32'h1,   1'b0, 1'b0, 1'b1);
        add_row(act_init,  16'h0000, 32'h0, 32'h0,   1'b0, 1'b0, 1'b0);
        add_row(act_read,  16'h2004, 32'h0, 32'h0,   1'b0, 1'b0, 1'b0);
    endtask

    //--------------------------------------------------------------------------
    // Main sequence
    //--------------------------------------------------------------------------
    initial
    begin
        int unsigned seed_val;
        int          errs_before;
        logic [3:0]  psel_vec;
        seed_val             = $urandom(38079);
        error_count          = 0;
        pass_count           = 0;
        FIC_2_APB_M_PRESET_N = 1'b0;
        m_psel               = 1'b0;
        m_penable            = 1'b0;
        m_pwrite             = 1'b0;
        m_paddr              = '0;
        m_pwdata             = '0;
        init_done            = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (3) @(posedge FIC_2_APB_M_PCLK);
        #1;
        FIC_2_APB_M_PRESET_N = 1'b1;

        // State straight out of reset
        errs_before = error_count;
        psel_vec    = {s_psel[3], s_psel[2], s_psel[1], s_psel[0]};
        check_value("m_pready after reset", m_pready, 1'b1);
        check_value("config_done after reset", config_done, 1'b0);
        check_value("clr_init_done after reset", clr_init_done, 1'b0);
        check_value("slave psel after reset", psel_vec, 4'b0);
        if (error_count == errs_before)
        begin
            pass_count++;
            $display("Reset check passed");
        end
        else
            $display("Reset check failed");

        for (int i = 0; i < rows.size(); i++)
            apply_row(i, rows[i]);

        $display("Tests: %0d, passed: %0d, errors: %0d",
                 rows.size() + 1, pass_count, error_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // Watchdog allows 20 cycles per row on top of reset
    initial
    begin
        cfg_bridge_pkg::bridge_state_t seq_state;
        wait (table_ready);
        repeat (rows.size() * 20 + 10) @(posedge FIC_2_APB_M_PCLK);
        seq_state = i_dut.i_seq.state;
        $display("Timeout: the run did not finish in time, bridge state %s",
                 seq_state.name());
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb_apb_slave_model.sv
module tb_apb_slave_model #(
    parameter int wait_states = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  cfg_bridge_pkg::paddr_t paddr,
    input  cfg_bridge_pkg::data_t  pwdata,
    output cfg_bridge_pkg::data_t  prdata,
    output logic                   pready,
    output logic                   pslverr
);

    timeunit 1ns;
    timeprecision 100ps;

    // 16 words, indexed by address bits 5:2
    cfg_bridge_pkg::data_t mem [16];
    int                    wait_cnt;
    logic [3:0]            idx;
    logic                  err_region;

    assign idx        = paddr[5:2];
    // Bits 11:8 all ones form the error region
    assign err_region = &paddr[11:8];

    //--------------------------------------------------------------------------
    // Wait states
    //--------------------------------------------------------------------------
    // Counts access cycles until ready, back to zero after completion
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wait_cnt <= 0;
        else if (psel && penable && !pready)
            wait_cnt <= wait_cnt + 1;
        else
            wait_cnt <= 0;
    end

    assign pready  = (wait_cnt == wait_states);
    assign pslverr = err_region;
    assign prdata  = err_region ? '0 : mem[idx];

    // Word memory, no write in the error region
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 16; i++)
                mem[i] <= '0;
        end
        else if (psel && penable && pready && pwrite && !err_region)
            mem[idx] <= pwdata;
    end

endmodule

// File: sf2_config_bridge.sv
module sf2_config_bridge #(
    parameter int sync_stages = 2
) (
    input  logic                   FIC_2_APB_M_PCLK,
    input  logic                   FIC_2_APB_M_PRESET_N,
    // Master side
    input  logic                   m_psel,
    input  logic                   m_penable,
    input  logic                   m_pwrite,
    input  cfg_bridge_pkg::paddr_t m_paddr,
    input  cfg_bridge_pkg::data_t  m_pwdata,
    output cfg_bridge_pkg::data_t  m_prdata,
    output logic                   m_pready,
    output logic                   m_pslverr,
    // MDDR
    output logic                   mddr_psel,
    output logic                   mddr_penable,
    output logic                   mddr_pwrite,
    output cfg_bridge_pkg::paddr_t mddr_paddr,
    output cfg_bridge_pkg::data_t  mddr_pwdata,
    input  cfg_bridge_pkg::data_t  mddr_prdata,
    input  logic                   mddr_pready,
    input  logic                   mddr_pslverr,
    // FDDR
    output logic                   fddr_psel,
    output logic                   fddr_penable,
    output logic                   fddr_pwrite,
    output cfg_bridge_pkg::paddr_t fddr_paddr,
    output cfg_bridge_pkg::data_t  fddr_pwdata,
    input  cfg_bridge_pkg::data_t  fddr_prdata,
    input  logic                   fddr_pready,
    input  logic                   fddr_pslverr,
    // SERDESIF_0
    output logic                   sdif0_psel,
    output logic                   sdif0_penable,
    output logic                   sdif0_pwrite,
    output cfg_bridge_pkg::paddr_t sdif0_paddr,
    output cfg_bridge_pkg::data_t  sdif0_pwdata,
    input  cfg_bridge_pkg::data_t  sdif0_prdata,
    input  logic                   sdif0_pready,
    input  logic                   sdif0_pslverr,
    // SERDESIF_1
    output logic                   sdif1_psel,
    output logic                   sdif1_penable,
    output logic                   sdif1_pwrite,
    output cfg_bridge_pkg::paddr_t sdif1_paddr,
    output cfg_bridge_pkg::data_t  sdif1_pwdata,
    input  cfg_bridge_pkg::data_t  sdif1_prdata,
    input  logic                   sdif1_pready,
    input  logic                   sdif1_pslverr,
    // Configuration handshake
    input  logic                   init_done,
    output logic                   config_done,
    output logic                   clr_init_done
);

    // Sequencer to decoder, and decoder to internal registers
    cfg_apb_if bridge_bus ();
    cfg_apb_if int_bus ();

    apb_bridge_seq i_seq (
        .clk       (FIC_2_APB_M_PCLK),
        .rst_n     (FIC_2_APB_M_PRESET_N),
        .m_psel    (m_psel),
        .m_penable (m_penable),
        .m_pwrite  (m_pwrite),
        .m_paddr   (m_paddr),
        .m_pwdata  (m_pwdata),
        .m_prdata  (m_prdata),
        .m_pready  (m_pready),
        .m_pslverr (m_pslverr),
        .bus       (bridge_bus.requester)
    );

    apb_slave_decoder i_dec (
        .bus           (bridge_bus.completer),
        .int_bus       (int_bus.requester),
        .mddr_psel     (mddr_psel),
        .mddr_penable  (mddr_penable),
        .mddr_pwrite   (mddr_pwrite),
        .mddr_paddr    (mddr_paddr),
        .mddr_pwdata   (mddr_pwdata),
        .mddr_prdata   (mddr_prdata),
        .mddr_pready   (mddr_pready),
        .mddr_pslverr  (mddr_pslverr),
        .fddr_psel     (fddr_psel),
        .fddr_penable  (fddr_penable),
        .fddr_pwrite   (fddr_pwrite),
        .fddr_paddr    (fddr_paddr),
        .fddr_pwdata   (fddr_pwdata),
        .fddr_prdata   (fddr_prdata),
        .fddr_pready   (fddr_pready),
        .fddr_pslverr  (fddr_pslverr),
        .sdif0_psel    (sdif0_psel),
        .sdif0_penable (sdif0_penable),
        .sdif0_pwrite  (sdif0_pwrite),
        .sdif0_paddr   (sdif0_paddr),
        .sdif0_pwdata  (sdif0_pwdata),
        .sdif0_prdata  (sdif0_prdata),
        .sdif0_pready  (sdif0_pready),
        .sdif0_pslverr (sdif0_pslverr),
        .sdif1_psel    (sdif1_psel),
        .sdif1_penable (sdif1_penable),
        .sdif1_pwrite  (sdif1_pwrite),
        .sdif1_paddr   (sdif1_paddr),
        .sdif1_pwdata  (sdif1_pwdata),
        .sdif1_prdata  (sdif1_prdata),
        .sdif1_pready  (sdif1_pready),
        .sdif1_pslverr (sdif1_pslverr)
    );

    cfg_regs #(
        .sync_stages (sync_stages)
    ) i_regs (
        .clk           (FIC_2_APB_M_PCLK),
        .rst_n         (FIC_2_APB_M_PRESET_N),
        .bus           (int_bus.completer),
        .init_done     (init_done),
        .config_done   (config_done),
        .clr_init_done (clr_init_done)
    );

endmodule

// File: cfg_regs.sv
module cfg_regs #(
    parameter int sync_stages = 2
) (
    input  logic         clk,
    input  logic         rst_n,
    cfg_apb_if.completer bus,
    input  logic         init_done,
    output logic         config_done,
    output logic         clr_init_done
);

    // One flop past the synchronizer for edge detection
    logic [sync_stages:0]        init_sync;
    logic                        init_done_s;
    logic                        init_fall;
    logic                        wr_en;
    cfg_bridge_pkg::reg_offset_t offset;

    //--------------------------------------------------------------------------
    // INIT_DONE synchronizer
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            init_sync <= '0;
        else
            init_sync <= {init_sync[sync_stages-1:0], init_done};
    end

    assign init_done_s = init_sync[sync_stages-1];
    assign init_fall   = init_sync[sync_stages] & ~init_done_s;

    //--------------------------------------------------------------------------
    // Register writes
    //--------------------------------------------------------------------------
    // Always ready, so the access phase edge completes the write
    assign offset = bus.paddr[3:2];
    assign wr_en  = bus.psel & bus.penable & bus.pwrite;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            config_done   <= 1'b0;
            clr_init_done <= 1'b0;
        end
        else
        begin
            if (wr_en && offset == cfg_bridge_pkg::ctrl_offset)
                config_done <= bus.pwdata[0];

            // A new request wins over a falling edge in the same cycle
            if (wr_en && offset == cfg_bridge_pkg::clr_offset && bus.pwdata[0])
                clr_init_done <= 1'b1;
            else if (init_fall)
                clr_init_done <= 1'b0;
        end
    end

    //--------------------------------------------------------------------------
    // Read data
    //--------------------------------------------------------------------------
    always_comb
    begin
        bus.prdata = '0;
        case (offset)
            cfg_bridge_pkg::ctrl_offset:   bus.prdata[0] = config_done;
            cfg_bridge_pkg::status_offset: bus.prdata[0] = init_done_s;
            cfg_bridge_pkg::clr_offset:    bus.prdata[0] = clr_init_done;
            // Offset 3 reads zero
            default:                       bus.prdata[0] = 1'b0;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

endmodule

// File: apb_slave_decoder.sv
module apb_slave_decoder (
    cfg_apb_if.completer           bus,
    cfg_apb_if.requester           int_bus,
    // MDDR
    output logic                   mddr_psel,
    output logic                   mddr_penable,
    output logic                   mddr_pwrite,
    output cfg_bridge_pkg::paddr_t mddr_paddr,
    output cfg_bridge_pkg::data_t  mddr_pwdata,
    input  cfg_bridge_pkg::data_t  mddr_prdata,
    input  logic                   mddr_pready,
    input  logic                   mddr_pslverr,
    // FDDR
    output logic                   fddr_psel,
    output logic                   fddr_penable,
    output logic                   fddr_pwrite,
    output cfg_bridge_pkg::paddr_t fddr_paddr,
    output cfg_bridge_pkg::data_t  fddr_pwdata,
    input  cfg_bridge_pkg::data_t  fddr_prdata,
    input  logic                   fddr_pready,
    input  logic                   fddr_pslverr,
    // SERDESIF_0
    output logic                   sdif0_psel,
    output logic                   sdif0_penable,
    output logic                   sdif0_pwrite,
    output cfg_bridge_pkg::paddr_t sdif0_paddr,
    output cfg_bridge_pkg::data_t  sdif0_pwdata,
    input  cfg_bridge_pkg::data_t  sdif0_prdata,
    input  logic                   sdif0_pready,
    input  logic                   sdif0_pslverr,
    // SERDESIF_1
    output logic                   sdif1_psel,
    output logic                   sdif1_penable,
    output logic                   sdif1_pwrite,
    output cfg_bridge_pkg::paddr_t sdif1_paddr,
    output cfg_bridge_pkg::data_t  sdif1_pwdata,
    input  cfg_bridge_pkg::data_t  sdif1_prdata,
    input  logic                   sdif1_pready,
    input  logic                   sdif1_pslverr
);

    cfg_bridge_pkg::slave_sel_t sel;

    //--------------------------------------------------------------------------
    // Address decode
    //--------------------------------------------------------------------------
    // 15 14 13 12
    //  1  1  x  x   SERDESIF_1
    //  1  0  x  x   SERDESIF_0
    //  0  x  1  x   internal registers
    //  0  x  0  1   FDDR
    //  0  x  0  0   MDDR
    // Bit 14 is a don't care below the SERDES region, giving aliases
    always_comb
    begin
        sel = '0;
        if (bus.paddr[cfg_bridge_pkg::sdif_bit])
        begin
            if (bus.paddr[cfg_bridge_pkg::sdif_unit_bit])
                sel[cfg_bridge_pkg::sdif1_bit] = 1'b1;
            else
                sel[cfg_bridge_pkg::sdif0_bit] = 1'b1;
        end
        else if (bus.paddr[cfg_bridge_pkg::int_region_bit])
            sel[cfg_bridge_pkg::int_bit] = 1'b1;
        else if (bus.paddr[cfg_bridge_pkg::fddr_region_bit])
            sel[cfg_bridge_pkg::fddr_bit] = 1'b1;
        else
            sel[cfg_bridge_pkg::mddr_bit] = 1'b1;
    end

    //--------------------------------------------------------------------------
    // Request fan-out
    //--------------------------------------------------------------------------
    // Only the selected slave sees psel and penable
    assign mddr_psel     = bus.psel    & sel[cfg_bridge_pkg::mddr_bit];
    assign mddr_penable  = bus.penable & sel[cfg_bridge_pkg::mddr_bit];
    assign fddr_psel     = bus.psel    & sel[cfg_bridge_pkg::fddr_bit];
    assign fddr_penable  = bus.penable & sel[cfg_bridge_pkg::fddr_bit];
    assign sdif0_psel    = bus.psel    & sel[cfg_bridge_pkg::sdif0_bit];
    assign sdif0_penable = bus.penable & sel[cfg_bridge_pkg::sdif0_bit];
    assign sdif1_psel    = bus.psel    & sel[cfg_bridge_pkg::sdif1_bit];
    assign sdif1_penable = bus.penable & sel[cfg_bridge_pkg::sdif1_bit];
    assign int_bus.psel    = bus.psel    & sel[cfg_bridge_pkg::int_bit];
    assign int_bus.penable = bus.penable & sel[cfg_bridge_pkg::int_bit];

    // Address, direction and write data go to every slave
    assign mddr_paddr     = bus.paddr;
    assign fddr_paddr     = bus.paddr;
    assign sdif0_paddr    = bus.paddr;
    assign sdif1_paddr    = bus.paddr;
    assign int_bus.paddr  = bus.paddr;
    assign mddr_pwrite    = bus.pwrite;
    assign fddr_pwrite    = bus.pwrite;
    assign sdif0_pwrite   = bus.pwrite;
    assign sdif1_pwrite   = bus.pwrite;
    assign int_bus.pwrite = bus.pwrite;
    assign mddr_pwdata    = bus.pwdata;
    assign fddr_pwdata    = bus.pwdata;
    assign sdif0_pwdata   = bus.pwdata;
    assign sdif1_pwdata   = bus.pwdata;
    assign int_bus.pwdata = bus.pwdata;

    //--------------------------------------------------------------------------
    // Response return
    //--------------------------------------------------------------------------
    always_comb
    begin
        // Ready with no data if nothing matches
        bus.prdata  = '0;
        bus.pready  = 1'b1;
        bus.pslverr = 1'b0;
        case (1'b1)
            sel[cfg_bridge_pkg::mddr_bit]:
            begin
                bus.prdata  = mddr_prdata;
                bus.pready  = mddr_pready;
                bus.pslverr = mddr_pslverr;
            end
            sel[cfg_bridge_pkg::fddr_bit]:
            begin
                bus.prdata  = fddr_prdata;
                bus.pready  = fddr_pready;
                bus.pslverr = fddr_pslverr;
            end
            sel[cfg_bridge_pkg::sdif0_bit]:
            begin
                bus.prdata  = sdif0_prdata;
                bus.pready  = sdif0_pready;
                bus.pslverr = sdif0_pslverr;
            end
            sel[cfg_bridge_pkg::sdif1_bit]:
            begin
                bus.prdata  = sdif1_prdata;
                bus.pready  = sdif1_pready;
                bus.pslverr = sdif1_pslverr;
            end
            sel[cfg_bridge_pkg::int_bit]:
            begin
                bus.prdata  = int_bus.prdata;
                bus.pready  = int_bus.pready;
                bus.pslverr = int_bus.pslverr;
            end
            default:
            begin
                bus.prdata = '0;
            end
        endcase
    end

endmodule

// File: apb_bridge_seq.sv
module apb_bridge_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    // Upstream master
    input  logic                   m_psel,
    input  logic                   m_penable,
    input  logic                   m_pwrite,
    input  cfg_bridge_pkg::paddr_t m_paddr,
    input  cfg_bridge_pkg::data_t  m_pwdata,
    output cfg_bridge_pkg::data_t  m_prdata,
    output logic                   m_pready,
    output logic                   m_pslverr,
    // Downstream toward the decoder
    cfg_apb_if.requester           bus
);

    cfg_bridge_pkg::bridge_state_t state;

    // Captured master request
    cfg_bridge_pkg::paddr_t paddr_q;
    cfg_bridge_pkg::data_t  pwdata_q;
    logic                   pwrite_q;

    //--------------------------------------------------------------------------
    // Request capture
    //--------------------------------------------------------------------------
    // Sampled on every idle edge, so the value taken with the master
    // setup cycle is the one held for the whole downstream transfer
    always_ff @(posedge clk)
    begin
        if (state == cfg_bridge_pkg::idle)
        begin
            paddr_q  <= m_paddr;
            pwrite_q <= m_pwrite;
            pwdata_q <= m_pwdata;
        end
    end

    //--------------------------------------------------------------------------
    // Sequencer
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= cfg_bridge_pkg::idle;
            m_pready  <= 1'b1;
            m_prdata  <= '0;
            m_pslverr <= 1'b0;
        end
        else
        begin
            case (state)
                cfg_bridge_pkg::idle:
                begin
                    // Master setup phase, stall it until the slave answers
                    if (m_psel && !m_penable)
                    begin
                        state    <= cfg_bridge_pkg::setup;
                        m_pready <= 1'b0;
                    end
                end
                cfg_bridge_pkg::setup:
                begin
                    state <= cfg_bridge_pkg::access;
                end
                cfg_bridge_pkg::access:
                begin
                    // Hold here for slave wait states
                    if (bus.pready)
                    begin
                        state     <= cfg_bridge_pkg::idle;
                        m_prdata  <= bus.prdata;
                        m_pslverr <= bus.pslverr;
                        m_pready  <= 1'b1;
                    end
                end
                default:
                begin
                    state <= cfg_bridge_pkg::idle;
                end
            endcase
        end
    end

    // Downstream phase signals straight from the state
    assign bus.psel    = (state != cfg_bridge_pkg::idle);
    assign bus.penable = (state == cfg_bridge_pkg::access);
    assign bus.paddr   = paddr_q;
    assign bus.pwrite  = pwrite_q;
    assign bus.pwdata  = pwdata_q;

endmodule

// File: cfg_apb_if.sv
interface cfg_apb_if;

    // Request side, held stable from setup to completion
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    cfg_bridge_pkg::paddr_t paddr;
    cfg_bridge_pkg::data_t  pwdata;

    // Response side
    cfg_bridge_pkg::data_t  prdata;
    logic                   pready;
    logic                   pslverr;

    modport requester (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport completer (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// File: cfg_bridge_pkg.sv
package cfg_bridge_pkg;

    //--------------------------------------------------------------------------
    // Bus widths
    //--------------------------------------------------------------------------
    // Word address as seen by the downstream slaves
    typedef logic [15:2] paddr_t;
    typedef logic [31:0] data_t;

    // Internal register index, address bits 3:2
    typedef logic [1:0] reg_offset_t;

    localparam reg_offset_t ctrl_offset   = 2'd0;
    localparam reg_offset_t status_offset = 2'd1;
    localparam reg_offset_t clr_offset    = 2'd2;

    //--------------------------------------------------------------------------
    // Slave decode
    //--------------------------------------------------------------------------
    // One-hot select, exactly one bit set for any address
    typedef logic [4:0] slave_sel_t;

    localparam int mddr_bit  = 0;
    localparam int fddr_bit  = 1;
    localparam int sdif0_bit = 2;
    localparam int sdif1_bit = 3;
    localparam int int_bit   = 4;

    // Address bits that steer the decode
    localparam int sdif_bit        = 15;
    localparam int sdif_unit_bit   = 14;
    localparam int int_region_bit  = 13;
    localparam int fddr_region_bit = 12;

    // Downstream sequencer states
    typedef enum logic [1:0] {idle, setup, access} bridge_state_t;

endpackage
